/* sim.f */
hdl/s32xPkg.sv
hdl/regBusIf.sv
hdl/fifoIf.sv
hdl/mdBusSlave.sv
hdl/shBusSlave.sv
hdl/sysRegFile.sv
hdl/dmaFifo.sv
hdl/s32xSysIf.sv
dv/s32xSysIfProps.sv
dv/tbS32xSysIf.sv

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module tbS32xSysIf -f sim.f -o simTb \
	> build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/simTb > sim.log 2>&1 || true
grep -qx "ALL CHECKS PASSED" sim.log && echo "simulation passed" || { cat sim.log; exit 1; }

/* dv/tbS32xSysIf.sv */
`timescale 1ns/100ps
`default_nettype none

module tbS32xSysIf;

	localparam logic [22:0] mdRegVa = 23'h50A880;	// Byte address A15100
	localparam logic [22:0] mdIdVa  = 23'h509876;	// Byte address A130EC
	localparam logic [9:0]  shPage  = 10'h040;
	localparam logic [31:0] idExp   = "MARS";
	localparam int dtackLimit = 16;
	localparam int mdSyncCycles = 3;	// Two sync flops and the edge flop

	localparam logic [4:0] ofsAdcr   = 5'd0;
	localparam logic [4:0] ofsIcr    = 5'd1;
	localparam logic [4:0] ofsDcr    = 5'd3;
	localparam logic [4:0] ofsDlr    = 5'd8;
	localparam logic [4:0] ofsFifo   = 5'd9;
	localparam logic [4:0] ofsCmdClr = 5'd13;
	localparam logic [4:0] ofsComm0  = 5'd16;

	localparam logic [2:0] irqOn  = 3'b011;
	localparam logic [2:0] irqOff = 3'b111;

	logic        CLK;
	logic        RST_N;
	logic [23:1] va;
	logic [15:0] vdi;
	logic [15:0] vdo;
	logic        asN;
	logic        lwrN;
	logic        uwrN;
	logic        cas0N;
	logic        dtackN;
	logic [17:1] sha;
	logic [15:0] shdi;
	logic [15:0] shdo;
	logic        shCs0mN;
	logic        shCs0sN;
	logic        shBsN;
	logic        shRdWrN;
	logic        shRdN;
	logic        shDqmllN;
	logic        shDqmluN;
	logic        shResN;
	logic        shDreq0N;
	logic [2:0]  shMirlN;
	logic [2:0]  shSirlN;

	int   dreqPulses = 0;
	logic dreqPrev = 1'b1;

	s32xSysIf #(.fifoDepth(8)) i_dut (.*);

	always #20 CLK = ~CLK;

	// Falling edges of the DMA request
	always @(posedge CLK) begin
		if (dreqPrev && !shDreq0N)
			dreqPulses <= dreqPulses + 1;
		dreqPrev <= shDreq0N;
	end

	task automatic checkValue(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "value check failed");
		end
	endtask

	task automatic waitDtack(input logic level, input string what);
		int   n;
		logic seen;
		n = 0;
		seen = 1'b0;
		while (!seen && n < dtackLimit) begin
			@(negedge CLK);
			seen = dtackN === level;
			n++;
		end
		if (!seen) begin
			$display("timeout: dtackN did not become %b within %0d cycles during %s",
				level, dtackLimit, what);
			$display("CHECKS FAILED");
			$fatal(1, "MD bus handshake timeout");
		end
	endtask

	task automatic mdWrite(input logic [4:0] ofs, input logic [15:0] data, input logic [1:0] be);
		@(posedge CLK);
		#2;
		va   = mdRegVa + 23'(ofs);
		vdi  = data;
		asN  = 1'b0;
		uwrN = ~be[1];
		lwrN = ~be[0];
		waitDtack(1'b0, "MD write");
		@(posedge CLK);
		#2;
		asN  = 1'b1;
		uwrN = 1'b1;
		lwrN = 1'b1;
		waitDtack(1'b1, "MD write release");
	endtask

	task automatic mdReadAt(input logic [22:0] addr, output logic [15:0] data);
		@(posedge CLK);
		#2;
		va    = addr;
		asN   = 1'b0;
		cas0N = 1'b0;
		waitDtack(1'b0, "MD read");
		data = vdo;
		@(posedge CLK);
		#2;
		asN   = 1'b1;
		cas0N = 1'b1;
		waitDtack(1'b1, "MD read release");
		// ID cycles end before the strobe edge reaches the slave
		repeat (mdSyncCycles) @(posedge CLK);
	endtask

	task automatic mdRead(input logic [4:0] ofs, output logic [15:0] data);
		mdReadAt(mdRegVa + 23'(ofs), data);
	endtask

	// Select cycle, then data cycle, then release
	task automatic shWrite(input logic slave, input logic [4:0] ofs, input logic [15:0] data,
		input logic [1:0] be);
		@(posedge CLK);
		#2;
		sha     = {shPage, 2'b00, ofs};
		shCs0mN = slave;
		shCs0sN = ~slave;
		shRdWrN = 1'b0;
		shBsN   = 1'b0;
		shdi    = data;
		@(posedge CLK);
		#2;
		shBsN    = 1'b1;
		shDqmluN = ~be[1];
		shDqmllN = ~be[0];
		@(posedge CLK);
		#2;
		shCs0mN  = 1'b1;
		shCs0sN  = 1'b1;
		shRdWrN  = 1'b1;
		shDqmluN = 1'b1;
		shDqmllN = 1'b1;
	endtask

	task automatic shRead(input logic slave, input logic [4:0] ofs, output logic [15:0] data);
		@(posedge CLK);
		#2;
		sha     = {shPage, 2'b00, ofs};
		shCs0mN = slave;
		shCs0sN = ~slave;
		shRdWrN = 1'b1;
		shBsN   = 1'b0;
		@(posedge CLK);
		#2;
		shBsN = 1'b1;
		shRdN = 1'b0;
		@(posedge CLK);
		#2;
		shRdN   = 1'b1;
		shCs0mN = 1'b1;
		shCs0sN = 1'b1;
		@(negedge CLK);
		data = shdo;
	endtask

	task automatic testResetAndId();
		logic [15:0] r;
		mdRead(ofsAdcr, r);
		checkValue("vdo (ADCR after reset)", r, 16'h1 << 7);
		checkValue("shResN", 16'(shResN), 16'h0);
		mdReadAt(mdIdVa, r);
		checkValue("vdo (ID upper)", r, idExp[31:16]);
		mdReadAt(mdIdVa + 23'd1, r);
		checkValue("vdo (ID lower)", r, idExp[15:0]);
		mdWrite(ofsAdcr, 16'h1 << 1, 2'b11);	// RES
		@(negedge CLK);
		checkValue("shResN", 16'(shResN), 16'h1);
		mdRead(ofsAdcr, r);
		checkValue("vdo (ADCR)", r, (16'h1 << 7) | (16'h1 << 1));
	endtask

	task automatic testCommPorts();
		logic [15:0] commExp [8];
		logic [15:0] r;
		logic [15:0] v;
		for (int i = 0; i < 8; i++) begin
			v = 16'($urandom);
			mdWrite(ofsComm0 + 5'(i), v, 2'b11);
			shRead(1'b0, ofsComm0 + 5'(i), r);
			checkValue($sformatf("shdo (COMM%0d)", i), r, v);
		end
		for (int i = 0; i < 8; i++) begin
			v = 16'($urandom);
			commExp[i] = v;
			shWrite(1'b1, ofsComm0 + 5'(i), v, 2'b11);
			mdRead(ofsComm0 + 5'(i), r);
			checkValue($sformatf("vdo (COMM%0d)", i), r, v);
		end
		v = 16'($urandom);
		mdWrite(ofsComm0 + 5'd3, v, 2'b01);	// Low lane only
		shRead(1'b0, ofsComm0 + 5'd3, r);
		checkValue("shdo (COMM3 low byte)", r, {commExp[3][15:8], v[7:0]});
		v = 16'($urandom);
		shWrite(1'b0, ofsComm0 + 5'd5, v, 2'b10);
		mdRead(ofsComm0 + 5'd5, r);
		checkValue("vdo (COMM5 high byte)", r, {v[15:8], commExp[5][7:0]});
	endtask

	task automatic testCmdInterrupt();
		mdWrite(ofsIcr, 16'h0001, 2'b11);	// INTM with the CMD mask still clear
		@(negedge CLK);
		checkValue("shMirlN", 16'(shMirlN), 16'(irqOff));
		shWrite(1'b0, ofsAdcr, 16'h1 << 1, 2'b01);
		@(negedge CLK);
		checkValue("shMirlN", 16'(shMirlN), 16'(irqOn));
		checkValue("shSirlN", 16'(shSirlN), 16'(irqOff));
		mdWrite(ofsIcr, 16'h0003, 2'b11);
		@(negedge CLK);
		checkValue("shSirlN", 16'(shSirlN), 16'(irqOff));
		shWrite(1'b1, ofsAdcr, 16'h1 << 1, 2'b01);
		@(negedge CLK);
		checkValue("shSirlN", 16'(shSirlN), 16'(irqOn));
		shWrite(1'b0, ofsCmdClr, 16'h0000, 2'b11);
		@(negedge CLK);
		checkValue("shMirlN", 16'(shMirlN), 16'(irqOff));
		checkValue("shSirlN", 16'(shSirlN), 16'(irqOn));
		shWrite(1'b1, ofsCmdClr, 16'h0000, 2'b11);
		@(negedge CLK);
		checkValue("shSirlN", 16'(shSirlN), 16'(irqOff));
	endtask

	task automatic testDmaFifo();
		logic [15:0] words [8];
		logic [15:0] r;
		int          base;
		int          expPulses;
		mdWrite(ofsDlr, 16'd8, 2'b11);
		mdWrite(ofsDcr, 16'h1 << 2, 2'b11);	// M68S
		base = dreqPulses;
		for (int k = 0; k < 8; k++) begin
			words[k] = 16'($urandom);
			mdWrite(ofsFifo, words[k], 2'b11);
			@(negedge CLK);
			expPulses = (k >= 3 ? 1 : 0) + (k == 7 ? 1 : 0);	// One per filled half
			checkValue($sformatf("shDreq0N pulses after push %0d", k + 1),
				16'(dreqPulses - base), 16'(expPulses));
		end
		mdRead(ofsDcr, r);
		checkValue("vdo (DCR)", r, 16'h1 << 7);
		shRead(1'b0, ofsDcr, r);
		checkValue("shdo (DMA status)", r, 16'h1 << 15);
		for (int k = 0; k < 8; k++) begin
			shRead(1'b0, ofsFifo, r);
			checkValue($sformatf("shdo (FIFO word %0d)", k), r, words[k]);
		end
		shRead(1'b0, ofsDcr, r);
		checkValue("shdo (DMA status)", r, 16'h1 << 14);
	endtask

	task automatic testFlush();
		logic [15:0] r;
		int          base;
		mdWrite(ofsDlr, 16'd8, 2'b11);
		mdWrite(ofsDcr, 16'h1 << 2, 2'b11);
		base = dreqPulses;
		for (int k = 0; k < 3; k++)
			mdWrite(ofsFifo, 16'($urandom), 2'b11);
		mdWrite(ofsDcr, 16'h0000, 2'b01);
		shRead(1'b0, ofsDcr, r);
		checkValue("shdo (DMA status)", r, 16'h1 << 14);
		checkValue("shDreq0N pulses", 16'(dreqPulses - base), 16'h0);
	endtask

	initial begin
		CLK      = 1'b0;
		RST_N    = 1'b0;
		va       = '0;
		vdi      = '0;
		asN      = 1'b1;
		lwrN     = 1'b1;
		uwrN     = 1'b1;
		cas0N    = 1'b1;
		sha      = '0;
		shdi     = '0;
		shCs0mN  = 1'b1;
		shCs0sN  = 1'b1;
		shBsN    = 1'b1;
		shRdWrN  = 1'b1;
		shRdN    = 1'b1;
		shDqmllN = 1'b1;
		shDqmluN = 1'b1;
		void'($urandom(32'hd3d1));
		repeat (3) @(posedge CLK);
		#2;
		RST_N = 1'b1;
		testResetAndId();
		testCommPorts();
		testCmdInterrupt();
		testDmaFifo();
		testFlush();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* dv/s32xSysIfProps.sv */
`timescale 1ns/100ps
`default_nettype none

module s32xSysIfProps (
	input logic CLK,
	input logic RST_N,
	input logic full,
	input logic empty,
	input logic shDreq0N
);

	flagsExclusive: assert property (@(posedge CLK) disable iff (!RST_N)
		!(full && empty))
		else $error("FIFO flags full and empty both set");

	// Request idle while held in reset
	dreqResetHigh: assert property (@(posedge CLK) !RST_N |-> shDreq0N)
		else $error("shDreq0N low during reset");

	dreqPulseWidth: assert property (@(posedge CLK) disable iff (!RST_N)
		$fell(shDreq0N) |=> !shDreq0N ##1 !shDreq0N ##1 shDreq0N)
		else $error("shDreq0N pulse not 3 cycles long");

endmodule

bind dmaFifo s32xSysIfProps fifoProps (
	.CLK      (CLK),
	.RST_N    (RST_N),
	.full     (fifo.full),
	.empty    (fifo.empty),
	.shDreq0N (shDreq0N)
);

`default_nettype wire

/* hdl/s32xSysIf.sv */
`timescale 1ns/100ps
`default_nettype none

module s32xSysIf #(
	parameter int fifoDepth = s32xPkg::FIFO_DEPTH_DEF
) (
	input  logic        CLK,
	input  logic        RST_N,
	input  logic [23:1] va,
	input  logic [15:0] vdi,
	output logic [15:0] vdo,
	input  logic        asN,
	input  logic        lwrN,
	input  logic        uwrN,
	input  logic        cas0N,
	output logic        dtackN,
	input  logic [17:1] sha,
	input  logic [15:0] shdi,
	output logic [15:0] shdo,
	input  logic        shCs0mN,
	input  logic        shCs0sN,
	input  logic        shBsN,
	input  logic        shRdWrN,
	input  logic        shRdN,
	input  logic        shDqmllN,
	input  logic        shDqmluN,
	output logic        shResN,
	output logic        shDreq0N,
	output logic [2:0]  shMirlN,
	output logic [2:0]  shSirlN
);
	regBusIf mdRegBus ();
	regBusIf shRegBus ();
	fifoIf   fifoBus ();
	logic    shSlave;

	mdBusSlave mdSlaveInst (
		.CLK, .RST_N, .va, .vdi, .vdo, .asN, .lwrN, .uwrN, .cas0N, .dtackN,
		.bus (mdRegBus.host)
	);

	shBusSlave shSlaveInst (
		.CLK, .RST_N, .sha, .shdi, .shdo, .shCs0mN, .shCs0sN, .shBsN,
		.shRdWrN, .shRdN, .shDqmllN, .shDqmluN,
		.bus     (shRegBus.host),
		.shSlave (shSlave)
	);

	sysRegFile regFileInst (
		.CLK, .RST_N,
		.md      (mdRegBus.regs),
		.sh      (shRegBus.regs),
		.shSlave (shSlave),
		.fifo    (fifoBus.ctrl),
		.shResN, .shMirlN, .shSirlN
	);

	dmaFifo #(.fifoDepth(fifoDepth)) fifoInst (
		.CLK, .RST_N,
		.fifo     (fifoBus.buffer),
		.shDreq0N (shDreq0N)
	);

endmodule

`default_nettype wire

/* hdl/dmaFifo.sv */
`timescale 1ns/100ps
`default_nettype none

module dmaFifo #(
	parameter int fifoDepth = s32xPkg::FIFO_DEPTH_DEF
) (
	input  logic  CLK,
	input  logic  RST_N,
	fifoIf.buffer fifo,
	output logic  shDreq0N
);
	localparam int ptrW = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;
	localparam int lvlW = $clog2(fifoDepth + 1);
	localparam int half = fifoDepth / 2;

	logic [15:0]     mem [fifoDepth];
	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;
	logic [lvlW-1:0] level;
	logic [lvlW-1:0] levelNext;
	logic            doPush;
	logic            doPop;
	logic            halfFilled;
	logic            halfDrained;
	logic            reqAvail;
	logic            reqAvailNext;
	logic            reqFire;
	logic [1:0]      reqCnt;

	function automatic logic [ptrW-1:0] ptrInc(input logic [ptrW-1:0] p);
		return (p == ptrW'(fifoDepth - 1)) ? '0 : p + 1'b1;
	endfunction

	assign fifo.full    = level == lvlW'(fifoDepth);
	assign fifo.empty   = level == '0;
	assign fifo.popData = mem[rdPtr];

	assign doPop     = fifo.pop & ~fifo.empty;
	assign doPush    = fifo.push & (~fifo.full | doPop);	// Slot freed by a pop
	assign levelNext = level + lvlW'(doPush) - lvlW'(doPop);

	assign halfFilled  = doPush & ((32'(wrPtr) % half) == half - 1);
	assign halfDrained = doPop & ((32'(rdPtr) % half) == half - 1) &
		(levelNext <= lvlW'(half));

	always_comb begin
		reqAvailNext = reqAvail;
		if (halfFilled)
			reqAvailNext = 1'b1;
		if (halfDrained)
			reqAvailNext = 1'b0;
	end

	// Ignored while a pulse is still running
	assign reqFire = (halfFilled | doPop) & reqAvailNext & (reqCnt == 2'd0);

	always_ff @(posedge CLK) begin
		if (doPush)
			mem[wrPtr] <= fifo.pushData;
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			wrPtr    <= '0;
			rdPtr    <= '0;
			level    <= '0;
			reqAvail <= 1'b0;
		end else if (fifo.flush) begin
			wrPtr    <= '0;
			rdPtr    <= '0;
			level    <= '0;
			reqAvail <= 1'b0;
		end else begin
			if (doPush)
				wrPtr <= ptrInc(wrPtr);
			if (doPop)
				rdPtr <= ptrInc(rdPtr);
			level    <= levelNext;
			reqAvail <= reqAvailNext;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N)
			reqCnt <= 2'd0;
		else if (reqFire)
			reqCnt <= 2'd3;
		else if (reqCnt != 2'd0)
			reqCnt <= reqCnt - 2'd1;
	end

	assign shDreq0N = reqCnt == 2'd0;

endmodule

`default_nettype wire

/* hdl/sysRegFile.sv */
`timescale 1ns/100ps
`default_nettype none

module sysRegFile (
	input  logic       CLK,
	input  logic       RST_N,
	regBusIf.regs      md,
	regBusIf.regs      sh,
	input  logic       shSlave,
	fifoIf.ctrl        fifo,
	output logic       shResN,
	output logic [2:0] shMirlN,
	output logic [2:0] shSirlN
);
	import s32xPkg::*;

	localparam logic [15:0] icrWmask = (16'h1 << ICR_INTM) | (16'h1 << ICR_INTS);

	logic [15:0] adcr;
	logic [15:0] icr;
	logic [15:0] dcr;
	logic [15:0] dlr;
	logic [15:0] dlrNext;
	logic [15:0] imrM;
	logic [15:0] imrS;
	logic [15:0] comm [8];
	logic        mdWrComm;
	logic        shWrComm;

	function automatic logic [15:0] laneWrite(input logic [15:0] old, input logic [15:0] data,
		input logic [1:0] be, input logic [15:0] mask);
		logic [15:0] laneMask;
		laneMask = {{8{be[1]}}, {8{be[0]}}} & mask;
		return (old & ~laneMask) | (data & laneMask);
	endfunction

	assign mdWrComm = md.wr & (md.ofs >= OFS_COMM0) & (md.ofs <= OFS_COMM7);
	assign shWrComm = sh.wr & (sh.ofs >= OFS_COMM0) & (sh.ofs <= OFS_COMM7);

	assign fifo.push     = md.wr & (md.ofs == OFS_FIFO) & dcr[DCR_M68S];
	assign fifo.pushData = md.wdata;
	assign fifo.pop      = sh.rd & (sh.ofs == OFS_FIFO);
	assign fifo.flush    = md.wr & (md.ofs == OFS_DCR) & md.byteEn[0] & ~md.wdata[DCR_M68S];

	assign dlrNext = dlr - 16'd1;

	// SH updates first so a colliding MD write overrides them
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			adcr <= ADCR_RESET;
			icr  <= '0;
		end else begin
			if (sh.wr && sh.ofs == OFS_ADCR && sh.byteEn[1])
				adcr[ADCR_FM] <= sh.wdata[ADCR_FM];
			if (md.wr && md.ofs == OFS_ADCR)
				adcr <= laneWrite(adcr, md.wdata, md.byteEn, ADCR_WMASK);
			if (sh.wr && sh.ofs == OFS_CMDCLR) begin
				if (shSlave)
					icr[ICR_INTS] <= 1'b0;
				else
					icr[ICR_INTM] <= 1'b0;
			end
			if (md.wr && md.ofs == OFS_ICR)
				icr <= laneWrite(icr, md.wdata, md.byteEn, icrWmask);
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			dcr <= '0;
			dlr <= '0;
		end else begin
			if (md.wr && md.ofs == OFS_DCR)
				dcr <= laneWrite(dcr, md.wdata, md.byteEn, DCR_WMASK);
			if (md.wr && md.ofs == OFS_DLR)
				dlr <= laneWrite(dlr, md.wdata, md.byteEn, 16'hFFFF);
			if (fifo.push) begin
				dlr <= dlrNext;
				if (dlrNext == 16'd0)
					dcr[DCR_M68S] <= 1'b0;	// Transfer done
			end
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			imrM <= '0;
			imrS <= '0;
		end else if (sh.wr && sh.ofs == OFS_ADCR && sh.byteEn[0]) begin
			if (shSlave)
				imrS <= sh.wdata & IMR_MASK;
			else
				imrM <= sh.wdata & IMR_MASK;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int i = 0; i < 8; i++)
				comm[i] <= '0;
		end else begin
			if (shWrComm)
				comm[sh.ofs[2:0]] <= laneWrite(comm[sh.ofs[2:0]], sh.wdata, sh.byteEn, 16'hFFFF);
			if (mdWrComm)
				comm[md.ofs[2:0]] <= laneWrite(comm[md.ofs[2:0]], md.wdata, md.byteEn, 16'hFFFF);
		end
	end

	always_comb begin
		case (md.ofs)
			OFS_ADCR: md.rdata = adcr;
			OFS_ICR:  md.rdata = icr;
			OFS_DCR:  md.rdata = dcr | (16'(fifo.full) << DCR_MD_FULL);
			OFS_DLR:  md.rdata = dlr;
			OFS_COMM0, OFS_COMM1, OFS_COMM2, OFS_COMM3,
			OFS_COMM4, OFS_COMM5, OFS_COMM6, OFS_COMM7:
				md.rdata = comm[md.ofs[2:0]];
			default:  md.rdata = 16'h0000;	// Data port is write only here
		endcase
	end

	always_comb begin
		case (sh.ofs)
			OFS_ADCR: sh.rdata = (shSlave ? imrS : imrM) | (adcr & (16'h1 << ADCR_FM));
			OFS_DCR:  sh.rdata = (16'(fifo.full) << DSR_FULL) | (16'(fifo.empty) << DSR_EMPTY) |
				(dcr & DCR_WMASK);
			OFS_DLR:  sh.rdata = dlr;
			OFS_FIFO: sh.rdata = fifo.popData;
			OFS_COMM0, OFS_COMM1, OFS_COMM2, OFS_COMM3,
			OFS_COMM4, OFS_COMM5, OFS_COMM6, OFS_COMM7:
				sh.rdata = comm[sh.ofs[2:0]];
			default:  sh.rdata = 16'h0000;
		endcase
	end

	assign shResN = adcr[ADCR_RES];

	// Only the CMD request at level 8 is kept
	assign shMirlN = (icr[ICR_INTM] & imrM[IMR_CMD]) ? 3'b011 : 3'b111;
	assign shSirlN = (icr[ICR_INTS] & imrS[IMR_CMD]) ? 3'b011 : 3'b111;

endmodule

`default_nettype wire

/* hdl/shBusSlave.sv */
`timescale 1ns/100ps
`default_nettype none

module shBusSlave (
	input  logic        CLK,
	input  logic        RST_N,
	input  logic [17:1] sha,
	input  logic [15:0] shdi,
	output logic [15:0] shdo,
	input  logic        shCs0mN,
	input  logic        shCs0sN,
	input  logic        shBsN,
	input  logic        shRdWrN,
	input  logic        shRdN,
	input  logic        shDqmllN,
	input  logic        shDqmluN,
	regBusIf.host       bus,
	output logic        shSlave
);
	import s32xPkg::*;

	logic        access;
	logic        winSel;
	logic        done;
	logic [15:0] rdReg;

	assign winSel = (~shCs0mN | ~shCs0sN) & (sha[17:8] == SH_SYSREG_PAGE);

	assign bus.wr = access & ~shRdWrN & (~shDqmllN | ~shDqmluN);
	assign bus.rd = access & shRdWrN & ~shRdN;
	assign done   = bus.wr | bus.rd;

	assign bus.ofs    = regOfs_t'(sha[5:1]);
	assign bus.byteEn = {~shDqmluN, ~shDqmllN};
	assign bus.wdata  = shdi;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			access  <= 1'b0;
			shSlave <= 1'b0;
		end else if (done) begin
			access <= 1'b0;
		end else if (!shBsN) begin
			access  <= winSel;
			shSlave <= ~shCs0sN;	// Master unless slave CS is active
		end
	end

	// Held until the next read
	always_ff @(posedge CLK) begin
		if (bus.rd)
			rdReg <= bus.rdata;
	end

	assign shdo = rdReg;

endmodule

`default_nettype wire

/* hdl/mdBusSlave.sv */
`timescale 1ns/100ps
`default_nettype none

module mdBusSlave (
	input  logic        CLK,
	input  logic        RST_N,
	input  logic [23:1] va,
	input  logic [15:0] vdi,
	output logic [15:0] vdo,
	input  logic        asN,
	input  logic        lwrN,
	input  logic        uwrN,
	input  logic        cas0N,
	output logic        dtackN,
	regBusIf.host       bus
);
	import s32xPkg::*;

	mdState_t    state;
	logic [1:0]  asSync;
	logic [2:0]  lwrSync;
	logic [2:0]  uwrSync;
	logic [2:0]  casSync;
	logic        wrFall;
	logic        casFall;
	logic        regSel;
	logic        idSel;
	logic        regHit;
	logic [15:0] rdReg;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			asSync  <= '1;
			lwrSync <= '1;
			uwrSync <= '1;
			casSync <= '1;
		end else begin
			asSync  <= {asSync[0], asN};
			lwrSync <= {lwrSync[1:0], lwrN};
			uwrSync <= {uwrSync[1:0], uwrN};
			casSync <= {casSync[1:0], cas0N};
		end
	end

	// Edge seen between the 2nd and 3rd flop
	assign wrFall  = (lwrSync[2] & ~lwrSync[1]) | (uwrSync[2] & ~uwrSync[1]);
	assign casFall = casSync[2] & ~casSync[1];

	assign regSel = va[23:6] == MD_SYSREG_BASE[23:6];
	assign idSel  = va[23:2] == MD_ID_BASE[23:2];
	assign regHit = (state == MD_IDLE) & ~asSync[1] & regSel;

	assign bus.wr     = regHit & wrFall;
	assign bus.rd     = regHit & casFall & ~wrFall;	// Write wins on a mixed edge
	assign bus.ofs    = regOfs_t'(va[5:1]);
	assign bus.byteEn = {~uwrSync[1], ~lwrSync[1]};
	assign bus.wdata  = vdi;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= MD_IDLE;
		end else begin
			case (state)
				MD_IDLE: if (bus.wr || bus.rd) state <= MD_ACK;
				MD_ACK:  if (asSync[1]) state <= MD_IDLE;
				default: state <= MD_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (bus.rd)
			rdReg <= bus.rdata;
	end

	// ID answers without a register cycle
	assign dtackN = (state != MD_ACK) & ~(idSel & ~asN);

	always_comb begin
		if (regSel)
			vdo = rdReg;
		else if (idSel)
			vdo = va[1] ? ADAPTER_ID[15:0] : ADAPTER_ID[31:16];
		else
			vdo = 16'h0000;
	end

endmodule

`default_nettype wire

/* hdl/fifoIf.sv */
`timescale 1ns/100ps
`default_nettype none

interface fifoIf;
	logic        push;
	logic [15:0] pushData;
	logic        pop;
	logic        flush;
	logic [15:0] popData;	// Head word
	logic        full;
	logic        empty;

	modport ctrl (
		output push, pushData, pop, flush,
		input  popData, full, empty
	);

	modport buffer (
		input  push, pushData, pop, flush,
		output popData, full, empty
	);

endinterface

`default_nettype wire

/* hdl/regBusIf.sv */
`timescale 1ns/100ps
`default_nettype none

interface regBusIf;
	import s32xPkg::*;

	logic        wr;
	logic        rd;
	regOfs_t     ofs;
	logic [1:0]  byteEn;	// Upper lane first
	logic [15:0] wdata;
	logic [15:0] rdata;

	modport host (
		output wr, rd, ofs, byteEn, wdata,
		input  rdata
	);

	modport regs (
		input  wr, rd, ofs, byteEn, wdata,
		output rdata
	);

endinterface

`default_nettype wire

/* hdl/s32xPkg.sv */
`default_nettype none

package s32xPkg;

	// Word offsets inside the system register window
	typedef enum logic [4:0] {
		OFS_ADCR   = 5'd0,	// Interrupt mask on the SH side
		OFS_ICR    = 5'd1,
		OFS_DCR    = 5'd3,
		OFS_DLR    = 5'd8,
		OFS_FIFO   = 5'd9,
		OFS_CMDCLR = 5'd13,
		OFS_COMM0  = 5'd16,
		OFS_COMM1  = 5'd17,
		OFS_COMM2  = 5'd18,
		OFS_COMM3  = 5'd19,
		OFS_COMM4  = 5'd20,
		OFS_COMM5  = 5'd21,
		OFS_COMM6  = 5'd22,
		OFS_COMM7  = 5'd23
	} regOfs_t;

	typedef enum logic {
		MD_IDLE,
		MD_ACK
	} mdState_t;

	localparam int ADCR_ADEN = 0;
	localparam int ADCR_RES  = 1;
	localparam int ADCR_REN  = 7;	// Hardwired to 1
	localparam int ADCR_FM   = 15;	// SH side only

	localparam int ICR_INTM = 0;
	localparam int ICR_INTS = 1;

	localparam int DCR_RV      = 0;
	localparam int DCR_DMA     = 1;
	localparam int DCR_M68S    = 2;
	localparam int DCR_MD_FULL = 7;

	localparam int IMR_CMD = 1;

	// SH view of the DMA control word
	localparam int DSR_FULL  = 15;
	localparam int DSR_EMPTY = 14;

	localparam logic [15:0] ADCR_WMASK = (16'h1 << ADCR_ADEN) | (16'h1 << ADCR_RES);
	localparam logic [15:0] DCR_WMASK  = (16'h1 << DCR_RV) | (16'h1 << DCR_DMA) |
		(16'h1 << DCR_M68S);
	localparam logic [15:0] IMR_MASK   = 16'h1 << IMR_CMD;

	localparam logic [15:0] ADCR_RESET = 16'h1 << ADCR_REN;

	localparam logic [23:0] MD_SYSREG_BASE = 24'hA15100;	// Up to A1513F
	localparam logic [23:0] MD_ID_BASE     = 24'hA130EC;
	localparam logic [31:0] ADAPTER_ID     = 32'h4D415253;	// "MARS"

	localparam logic [9:0] SH_SYSREG_PAGE = 10'h040;

	localparam int FIFO_DEPTH_DEF = 8;

endpackage

`default_nettype wire
